// ==== Bender.yml ====
package:
  name: ifu_fetch

export_include_dirs:
  - include

sources:
  - files:
      - source/ifu_pkg.sv
      - source/ifu_branch_predecode.sv
      - source/ifu_pc_gen.sv
      - source/ifu_ir_stage.sv
      - source/ifu_ifetch_top.sv
  - target: test
    files:
      - verification/ifu_props.sv
      - verification/ifu_tb.sv

// ==== include/ifu_params.svh ====
// Width, reset vector and PC increment macros for the instruction fetch unit

`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath width

// Data and address width of the fetch path
`define IFU_XLEN 32

////////////////////////////////////////////////////////////////////////////
// Fetch addresses

// First fetch address after reset
`define IFU_RESET_PC 32'h0000_1000

// Sequential PC step for a 32-bit instruction
`define IFU_INCR_32 4

// Sequential PC step for a compressed instruction
`define IFU_INCR_16 2

`endif

// ==== list.f ====
+incdir+include
source/ifu_pkg.sv
source/ifu_branch_predecode.sv
source/ifu_pc_gen.sv
source/ifu_ir_stage.sv
source/ifu_ifetch_top.sv
verification/ifu_props.sv
verification/ifu_tb.sv

// ==== source/ifu_branch_predecode.sv ====
// Combinational pre-decoder for length, jump/branch kind, offset and static prediction

`timescale 1ns/100ps
`default_nettype none

`include "ifu_params.svh"

module ifu_branch_predecode (
  input  logic [`IFU_XLEN-1:0] instr,
  output ifu_pkg::predecode_t  predecode
);

  logic                 rv32;
  logic                 quad1;
  logic [2:0]           c_funct3;
  logic [6:0]           opcode;

  logic                 dec_jal;
  logic                 dec_bxx;
  logic                 dec_cj;
  logic                 dec_cjal;
  logic                 dec_cbxx;

  logic [`IFU_XLEN-1:0] imm_jal;
  logic [`IFU_XLEN-1:0] imm_bxx;
  logic [`IFU_XLEN-1:0] imm_cj;
  logic [`IFU_XLEN-1:0] imm_cb;
  logic [`IFU_XLEN-1:0] bjp_imm;

  logic                 dec_bjp;
  logic                 prdt_taken;

  ////////////////////////////////////////////////////////////////////////////
  // Length and opcode fields

  // Low two bits all ones mean a 32-bit instruction
  assign rv32     = (instr[1:0] == 2'b11);
  // Compressed quadrant 1 holds C.J, C.JAL and C.Bxx
  assign quad1    = (instr[1:0] == 2'b01);
  assign c_funct3 = instr[15:13];
  assign opcode   = instr[6:0];

  ////////////////////////////////////////////////////////////////////////////
  // Jump and branch recognition

  assign dec_jal  = rv32 & (opcode == 7'b1101111);
  assign dec_bxx  = rv32 & (opcode == 7'b1100011);
  assign dec_cj   = quad1 & (c_funct3 == 3'b101);
  // C.JAL only exists on RV32
  assign dec_cjal = quad1 & (c_funct3 == 3'b001);
  // C.BEQZ and C.BNEZ
  assign dec_cbxx = quad1 & ((c_funct3 == 3'b110) | (c_funct3 == 3'b111));

  ////////////////////////////////////////////////////////////////////////////
  // Offset assembly

  // J-type offset, bit 20 down to 1
  assign imm_jal = {{(`IFU_XLEN-20){instr[31]}}, instr[19:12], instr[20],
                    instr[30:21], 1'b0};

  // B-type offset, bit 12 down to 1
  assign imm_bxx = {{(`IFU_XLEN-12){instr[31]}}, instr[7], instr[30:25],
                    instr[11:8], 1'b0};

  // CJ format shared by C.J and C.JAL
  assign imm_cj  = {{(`IFU_XLEN-11){instr[12]}}, instr[8], instr[10:9], instr[6],
                    instr[7], instr[2], instr[11], instr[5:3], 1'b0};

  // CB format, offset bit 8 down to 1
  assign imm_cb  = {{(`IFU_XLEN-8){instr[12]}}, instr[6:5], instr[2],
                    instr[11:10], instr[4:3], 1'b0};

  // Kinds are mutually exclusive by encoding
  always_comb begin
    if (dec_jal) begin
      bjp_imm = imm_jal;
    end else if (dec_bxx) begin
      bjp_imm = imm_bxx;
    end else if (dec_cj | dec_cjal) begin
      bjp_imm = imm_cj;
    end else begin
      bjp_imm = imm_cb;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Static prediction

  assign dec_bjp = dec_jal | dec_bxx | dec_cj | dec_cjal | dec_cbxx;

  // Jumps always taken, branches taken only when backward
  assign prdt_taken = dec_jal | dec_cj | dec_cjal
                    | ((dec_bxx | dec_cbxx) & bjp_imm[`IFU_XLEN-1]);

  assign predecode = '{rv32:       rv32,
                       bjp:        dec_bjp,
                       prdt_taken: prdt_taken,
                       offset:     bjp_imm};

endmodule

`default_nettype wire

// ==== source/ifu_ifetch_top.sv ====
// Fetch unit top level with the pre-decoder, PC generator and IR stage

`timescale 1ns/100ps
`default_nettype none

`include "ifu_params.svh"

module ifu_ifetch_top (
  input  logic                 clk,
  input  logic                 rst_n,
  // Fetch request channel
  output logic                 ifu_req_valid,
  input  logic                 ifu_req_ready,
  output ifu_pkg::fetch_req_t  ifu_req,
  // Fetch response channel
  input  logic                 ifu_rsp_valid,
  output logic                 ifu_rsp_ready,
  input  ifu_pkg::fetch_rsp_t  ifu_rsp,
  // IR stage toward the execute unit
  output logic                 ifu_o_valid,
  input  logic                 ifu_o_ready,
  output ifu_pkg::ir_out_t     ifu_o,
  // Pipeline flush, always accepted
  input  logic                 pipe_flush_req,
  input  logic [`IFU_XLEN-1:0] pipe_flush_pc,
  // Halt handshake
  input  logic                 ifu_halt_req,
  output logic                 ifu_halt_ack
);

  ifu_pkg::predecode_t  predecode;
  logic                 rsp_load;
  logic [`IFU_XLEN-1:0] pc_r;
  logic                 flush_real;
  logic                 ir_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Pre-decode of the returned instruction

  ifu_branch_predecode u_ifu_branch_predecode (
    .instr     (ifu_rsp.instr),
    .predecode (predecode)
  );

  ////////////////////////////////////////////////////////////////////////////
  // PC generation and request issue

  ifu_pc_gen u_ifu_pc_gen (
    .clk            (clk),
    .rst_n          (rst_n),
    .ifu_req_valid  (ifu_req_valid),
    .ifu_req_ready  (ifu_req_ready),
    .ifu_req        (ifu_req),
    .ifu_rsp_valid  (ifu_rsp_valid),
    .ifu_rsp_ready  (ifu_rsp_ready),
    .predecode      (predecode),
    .pipe_flush_req (pipe_flush_req),
    .pipe_flush_pc  (pipe_flush_pc),
    .ifu_halt_req   (ifu_halt_req),
    .ifu_halt_ack   (ifu_halt_ack),
    .ir_ready       (ir_ready),
    .rsp_load       (rsp_load),
    .pc_r           (pc_r),
    .flush_real     (flush_real)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Instruction register

  ifu_ir_stage u_ifu_ir_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .rsp_load    (rsp_load),
    .ifu_rsp     (ifu_rsp),
    .pc_r        (pc_r),
    .prdt_taken  (predecode.prdt_taken),
    .flush_real  (flush_real),
    .ir_ready    (ir_ready),
    .ifu_o_valid (ifu_o_valid),
    .ifu_o_ready (ifu_o_ready),
    .ifu_o       (ifu_o)
  );

endmodule

`default_nettype wire

// ==== source/ifu_ir_stage.sv ====
// Instruction-register stage holding the fetched instruction toward the execute unit

`timescale 1ns/100ps
`default_nettype none

`include "ifu_params.svh"

module ifu_ir_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rsp_load,
  input  ifu_pkg::fetch_rsp_t  ifu_rsp,
  input  logic [`IFU_XLEN-1:0] pc_r,
  input  logic                 prdt_taken,
  input  logic                 flush_real,
  output logic                 ir_ready,
  output logic                 ifu_o_valid,
  input  logic                 ifu_o_ready,
  output ifu_pkg::ir_out_t     ifu_o
);

  logic                 ir_valid_r;
  logic                 ir_valid_clr;
  logic                 o_hsk;
  logic [`IFU_XLEN-1:0] ir_r;
  logic [`IFU_XLEN-1:0] ir_pc_r;
  logic                 ir_err_r;
  logic                 ir_prdt_r;

  assign o_hsk = ifu_o_valid & ifu_o_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Valid bit

  // Emptied by the execute unit or by a flush
  assign ir_valid_clr = o_hsk | (flush_real & ir_valid_r);

  // Load wins when it meets an output handshake
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ir_valid_r <= 1'b0;
    end else if (rsp_load) begin
      ir_valid_r <= 1'b1;
    end else if (ir_valid_clr) begin
      ir_valid_r <= 1'b0;
    end
  end

  // Empty or being emptied
  assign ir_ready = ~ir_valid_r | ir_valid_clr;

  ////////////////////////////////////////////////////////////////////////////
  // Payload

  always_ff @(posedge clk) begin
    if (rsp_load) begin
      ir_r      <= ifu_rsp.instr;
      ir_pc_r   <= pc_r;
      ir_err_r  <= ifu_rsp.err;
      ir_prdt_r <= prdt_taken;
    end
  end

  assign ifu_o_valid = ir_valid_r;

  assign ifu_o = '{ir:         ir_r,
                   pc:         ir_pc_r,
                   buserr:     ir_err_r,
                   prdt_taken: ir_prdt_r};

endmodule

`default_nettype wire

// ==== source/ifu_pc_gen.sv ====
// PC register, reset request, delayed flush, outstanding flag, halt acknowledge and request issue

`timescale 1ns/100ps
`default_nettype none

`include "ifu_params.svh"

module ifu_pc_gen (
  input  logic                 clk,
  input  logic                 rst_n,
  output logic                 ifu_req_valid,
  input  logic                 ifu_req_ready,
  output ifu_pkg::fetch_req_t  ifu_req,
  input  logic                 ifu_rsp_valid,
  output logic                 ifu_rsp_ready,
  input  ifu_pkg::predecode_t  predecode,
  input  logic                 pipe_flush_req,
  input  logic [`IFU_XLEN-1:0] pipe_flush_pc,
  input  logic                 ifu_halt_req,
  output logic                 ifu_halt_ack,
  input  logic                 ir_ready,
  output logic                 rsp_load,
  output logic [`IFU_XLEN-1:0] pc_r,
  output logic                 flush_real
);

  logic                 req_hsk;
  logic                 rsp_hsk;
  logic                 reset_flag_r;
  logic                 reset_req_r;
  logic                 dly_flush_r;
  logic [`IFU_XLEN-1:0] dly_flush_pc_r;
  logic                 out_flag_r;
  logic                 halt_ack_r;
  logic                 halt_blk;
  logic                 ifu_no_outs;
  logic                 new_req_condi;
  logic                 ifu_new_req;
  logic                 bjp_req;
  logic [`IFU_XLEN-1:0] flush_pc;
  logic [`IFU_XLEN-1:0] pc_incr;
  logic [`IFU_XLEN-1:0] pc_add_op1;
  logic [`IFU_XLEN-1:0] pc_add_op2;
  logic [`IFU_XLEN-1:0] pc_nxt_pre;
  logic [`IFU_XLEN-1:0] pc_nxt;
  logic                 pc_ena;

  assign req_hsk = ifu_req_valid & ifu_req_ready;
  assign rsp_hsk = ifu_rsp_valid & ifu_rsp_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Reset request

  // High while in reset, drops at the first edge out of it
  always_ff @(posedge clk) begin
    reset_flag_r <= ~rst_n;
  end

  // Pending reset-vector fetch, cleared once issued
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reset_req_r <= 1'b0;
    end else if (reset_flag_r) begin
      reset_req_r <= 1'b1;
    end else if (req_hsk) begin
      reset_req_r <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Delayed flush

  // Flush that could not ride on a request this cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dly_flush_r <= 1'b0;
    end else if (pipe_flush_req & ~req_hsk) begin
      dly_flush_r <= 1'b1;
    end else if (req_hsk) begin
      dly_flush_r <= 1'b0;
    end
  end

  // Newest flush target
  always_ff @(posedge clk) begin
    if (pipe_flush_req) begin
      dly_flush_pc_r <= pipe_flush_pc;
    end
  end

  assign flush_real = pipe_flush_req | dly_flush_r;
  assign flush_pc   = pipe_flush_req ? pipe_flush_pc : dly_flush_pc_r;

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding flag and halt acknowledge

  // Set wins over clear when a response and a new request meet
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_flag_r <= 1'b0;
    end else if (req_hsk) begin
      out_flag_r <= 1'b1;
    end else if (rsp_hsk) begin
      out_flag_r <= 1'b0;
    end
  end

  // A valid response counts as returned even before it handshakes
  assign ifu_no_outs = ~out_flag_r | ifu_rsp_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halt_ack_r <= 1'b0;
    end else if (ifu_halt_req & ifu_no_outs) begin
      halt_ack_r <= 1'b1;
    end else if (~ifu_halt_req) begin
      halt_ack_r <= 1'b0;
    end
  end

  assign ifu_halt_ack = halt_ack_r;

  // Fetching stays stopped until the acknowledge has dropped again
  assign halt_blk = ifu_halt_req | halt_ack_r;

  ////////////////////////////////////////////////////////////////////////////
  // Next PC

  // Prediction only counts on a live response
  assign bjp_req = ifu_rsp_valid & predecode.bjp & predecode.prdt_taken;
  assign pc_incr = predecode.rv32 ? `IFU_INCR_32 : `IFU_INCR_16;

  // Predicted target, then reset vector, then sequential step
  assign pc_add_op1 = bjp_req     ? pc_r :
                      reset_req_r ? `IFU_RESET_PC :
                                    pc_r;
  assign pc_add_op2 = bjp_req     ? predecode.offset :
                      reset_req_r ? '0 :
                                    pc_incr;

  // Flush target beats everything
  assign pc_nxt_pre = flush_real ? flush_pc : (pc_add_op1 + pc_add_op2);
  assign pc_nxt     = {pc_nxt_pre[`IFU_XLEN-1:1], 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Request and response channels

  assign ifu_new_req   = ~reset_flag_r & ~halt_blk;
  // Free slot, or the only outstanding fetch returns now
  assign new_req_condi = ~out_flag_r | rsp_hsk;
  assign ifu_req_valid = ifu_new_req & new_req_condi;

  assign ifu_req = '{pc:  pc_nxt,
                     seq: ~flush_real & ~reset_req_r & ~bjp_req};

  // Flush drops the response in flight
  assign ifu_rsp_ready = ~reset_flag_r
                       & (flush_real | (ir_ready & ifu_req_ready & ~halt_blk));

  assign rsp_load = rsp_hsk & ~flush_real;

  // PC of the fetch now outstanding
  assign pc_ena = req_hsk | pipe_flush_req;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_r <= `IFU_RESET_PC;
    end else if (pc_ena) begin
      pc_r <= pc_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== source/ifu_pkg.sv ====
// Packed structs shared by the fetch request, response, pre-decode and IR paths

`default_nettype none

`include "ifu_params.svh"

package ifu_pkg;

  // Fetch request payload
  typedef struct packed {
    logic [`IFU_XLEN-1:0] pc;
    // Sequential fetch, no redirect
    logic                 seq;
  } fetch_req_t;

  // Fetch response payload
  typedef struct packed {
    logic [`IFU_XLEN-1:0] instr;
    // Bus error on this fetch
    logic                 err;
  } fetch_rsp_t;

  // Pre-decode result of the returned instruction
  typedef struct packed {
    logic                 rv32;
    // Any jump or branch
    logic                 bjp;
    logic                 prdt_taken;
    // Sign-extended jump or branch offset
    logic [`IFU_XLEN-1:0] offset;
  } predecode_t;

  // IR stage payload toward the execute unit
  typedef struct packed {
    logic [`IFU_XLEN-1:0] ir;
    logic [`IFU_XLEN-1:0] pc;
    logic                 buserr;
    logic                 prdt_taken;
  } ir_out_t;

endpackage

`default_nettype wire

// ==== verification/ifu_props.sv ====
// Bound assertions on the fetch request handshake, the single-outstanding rule and halt

`timescale 1ns/100ps
`default_nettype none

`include "ifu_params.svh"

module ifu_props (
  input wire logic                clk,
  input wire logic                rst_n,
  input wire logic                ifu_req_valid,
  input wire logic                ifu_req_ready,
  input wire ifu_pkg::fetch_req_t ifu_req,
  input wire logic                ifu_rsp_valid,
  input wire logic                ifu_rsp_ready,
  input wire logic                pipe_flush_req,
  input wire logic                ifu_halt_ack
);

  logic req_hsk;
  logic rsp_hsk;
  logic outstanding_r;

  assign req_hsk = ifu_req_valid & ifu_req_ready;
  assign rsp_hsk = ifu_rsp_valid & ifu_rsp_ready;

  // Shadow of the fetch in flight, a new request wins over a returning one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      outstanding_r <= 1'b0;
    end else if (req_hsk) begin
      outstanding_r <= 1'b1;
    end else if (rsp_hsk) begin
      outstanding_r <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request channel

  // Stalled payload holds unless a new flush retargets it
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (ifu_req_valid && !ifu_req_ready) |=>
      (!ifu_req_valid || pipe_flush_req || $stable(ifu_req)))
    else $error("request payload changed while stalled");

  // Only one fetch in flight
  one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    ifu_req_valid |-> (!outstanding_r || rsp_hsk))
    else $error("second request while one is outstanding");

  // Acknowledged halt blocks all requests
  halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    ifu_halt_ack |-> !ifu_req_valid)
    else $error("request issued while halted");

endmodule

`default_nettype wire

// ==== verification/ifu_tb.sv ====
// Fetch unit testbench with clock, fetch memory model, consumer, reference model and watchdog

`timescale 1ns/100ps
`default_nettype none

`include "ifu_params.svh"

module ifu_tb;

  // Planned output handshakes per phase
  localparam int N_RESET  = 1;
  localparam int N_STREAM = 60;
  localparam int N_FLUSH  = 80;
  localparam int N_RESUME = 10;
  localparam int LIMIT_CYCLES = (N_RESET + N_STREAM + N_FLUSH + N_RESUME) * 40;
  localparam logic [31:0] FAULT_PC = 32'h0000_1208;
  // Branch table kinds
  localparam logic [2:0] K_NONE = 3'd0, K_JAL = 3'd1, K_BEQ = 3'd2, K_BNE = 3'd3;
  localparam logic [2:0] K_CJ = 3'd4, K_CBNEZ = 3'd5;

  logic                 clk;
  logic                 rst_n;
  logic                 ifu_req_valid;
  logic                 ifu_req_ready;
  ifu_pkg::fetch_req_t  ifu_req;
  logic                 ifu_rsp_valid;
  logic                 ifu_rsp_ready;
  ifu_pkg::fetch_rsp_t  ifu_rsp;
  logic                 ifu_o_valid;
  logic                 ifu_o_ready;
  ifu_pkg::ir_out_t     ifu_o;
  logic                 pipe_flush_req;
  logic [31:0]          pipe_flush_pc;
  logic                 ifu_halt_req;
  logic                 ifu_halt_ack;

  integer      seed;
  int          errors, n_checks, n_deliv, n_buserr, n_flush, n_flush_stall, n_halt_req;
  int          n_redirect;
  int          cycle, base_err, target;
  bit          flush_en, halt_en, first_req, rsp_done, req_taken, mem_busy, flush_pend;
  logic [31:0] req_pc_s, mem_addr, flush_tgt;
  int          mem_cnt;
  string       test_name;
  // Expected delivery stream, one entry ahead
  ifu_pkg::ir_out_t exp_q[$];

  ifu_ifetch_top u_ifu_ifetch_top (.*);

  bind ifu_ifetch_top ifu_props u_ifu_props (
    .clk(clk), .rst_n(rst_n), .ifu_req_valid(ifu_req_valid),
    .ifu_req_ready(ifu_req_ready), .ifu_req(ifu_req), .ifu_rsp_valid(ifu_rsp_valid),
    .ifu_rsp_ready(ifu_rsp_ready), .pipe_flush_req(pipe_flush_req),
    .ifu_halt_ack(ifu_halt_ack)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Program image and reference rules

  function automatic logic [2:0] branch_kind(input logic [31:0] addr);
    case (addr)
      32'h1010, 32'h1110: branch_kind = K_JAL;
      32'h1050:           branch_kind = K_BEQ;
      32'h1140:           branch_kind = K_BNE;
      32'h1060:           branch_kind = K_CJ;
      32'h1100:           branch_kind = K_CBNEZ;
      default:            branch_kind = K_NONE;
    endcase
  endfunction

  function automatic logic [31:0] branch_off(input logic [31:0] addr);
    case (addr)
      32'h1010: branch_off = 32'h40;
      32'h1110: branch_off = 32'hf0;
      32'h1050: branch_off = 32'h20;
      32'h1140: branch_off = 32'hffff_ffc0;
      32'h1060: branch_off = 32'hc0;
      32'h1100: branch_off = 32'h10;
      default:  branch_off = 32'h0;
    endcase
  endfunction

  // RISC-V encodings built from the table, upper half of compressed words from the address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] o;
    logic [15:0] hi;
    logic [11:0] imm;
    o   = branch_off(addr);
    hi  = addr[15:0] ^ addr[31:16];
    imm = addr[11:0] ^ addr[23:12] ^ {4'h0, addr[31:24]};
    case (branch_kind(addr))
      K_JAL:   mem_word = {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'h6f};
      K_BEQ:   mem_word = {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], 7'h63};
      K_BNE:   mem_word = {o[12], o[10:5], 5'd2, 5'd1, 3'b001, o[4:1], o[11], 7'h63};
      K_CJ:    mem_word = {hi, 3'b101, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1],
                           o[5], 2'b01};
      K_CBNEZ: mem_word = {hi, 3'b111, o[8], o[4:3], 3'b000, o[7:6], o[2:1], o[5], 2'b01};
      default: mem_word = addr[3] ? {hi, 16'h0505} : {imm, 5'd0, 3'b000, 5'd1, 7'h13};
    endcase
  endfunction

  // Jumps taken, branches taken only backward
  function automatic logic pred_taken(input logic [31:0] addr);
    logic [31:0] off;
    off = branch_off(addr);
    case (branch_kind(addr))
      K_JAL, K_CJ:           pred_taken = 1'b1;
      K_BEQ, K_BNE, K_CBNEZ: pred_taken = off[31];
      default:               pred_taken = 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] next_pc_ref(input logic [31:0] pc);
    logic [2:0]  kind;
    logic [31:0] len;
    logic [31:0] nxt;
    kind = branch_kind(pc);
    if (kind == K_CJ || kind == K_CBNEZ) begin
      len = `IFU_INCR_16;
    end else if (kind != K_NONE) begin
      len = `IFU_INCR_32;
    end else begin
      len = pc[3] ? `IFU_INCR_16 : `IFU_INCR_32;
    end
    nxt = pred_taken(pc) ? pc + branch_off(pc) : pc + len;
    return {nxt[31:1], 1'b0};
  endfunction

  function automatic ifu_pkg::ir_out_t expected_entry(input logic [31:0] pc);
    ifu_pkg::ir_out_t e;
    e.ir         = mem_word(pc);
    e.pc         = pc;
    e.buserr     = (pc == FAULT_PC);
    e.prdt_taken = pred_taken(pc);
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    n_checks++;
    if (exp_v !== act_v) begin
      errors++;
      $display("Error %s: %s expected %h actual %h", test_name, name, exp_v, act_v);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, memory model and consumer, all driven on the falling edge

  always @(negedge clk) begin
    cycle++;
    rst_n = (cycle > 8);
    if (!rst_n) begin
      mem_busy = 1'b0;
    end else begin
      if (rsp_done) begin
        ifu_rsp_valid = 1'b0;
        mem_busy      = 1'b0;
      end
      if (req_taken) begin
        mem_busy = 1'b1;
        mem_addr = req_pc_s;
        mem_cnt  = $unsigned($random(seed)) % 4;
      end
      // Response after 0 to 3 idle cycles
      if (mem_busy && !ifu_rsp_valid) begin
        if (mem_cnt == 0) begin
          ifu_rsp_valid = 1'b1;
          ifu_rsp.instr = mem_word(mem_addr);
          ifu_rsp.err   = (mem_addr == FAULT_PC);
        end else begin
          mem_cnt--;
        end
      end
      ifu_req_ready = ($random(seed) & 3) != 0;
      ifu_o_ready   = ($random(seed) & 3) != 0;
      ifu_halt_req  = halt_en;
      pipe_flush_req = 1'b0;
      if (flush_en && (($random(seed) & 15) == 0)) begin
        pipe_flush_req = 1'b1;
        case ($unsigned($random(seed)) % 4)
          0:       pipe_flush_pc = `IFU_RESET_PC;
          1:       pipe_flush_pc = 32'h1100;
          2:       pipe_flush_pc = 32'h1204;
          default: pipe_flush_pc = 32'h1050;
        endcase
        n_flush++;
        if (!ifu_req_ready) n_flush_stall++;
      end
    end
    rsp_done  = 1'b0;
    req_taken = 1'b0;
  end

  // Channel handshakes sampled at the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (ifu_rsp_valid && ifu_rsp_ready) rsp_done = 1'b1;
      // Newest flush target rides on the next request
      if (pipe_flush_req) begin
        flush_pend = 1'b1;
        flush_tgt  = pipe_flush_pc;
      end
      if (ifu_req_valid && ifu_req_ready) begin
        req_taken = 1'b1;
        req_pc_s  = ifu_req.pc;
        if (first_req) begin
          check_value("first request pc", `IFU_RESET_PC, ifu_req.pc);
          check_value("first request seq", 32'd0, {31'd0, ifu_req.seq});
          first_req = 1'b0;
        end
        if (flush_pend) begin
          check_value("flush request pc", flush_tgt, ifu_req.pc);
          check_value("flush request seq", 32'd0, {31'd0, ifu_req.seq});
          n_redirect++;
          flush_pend = 1'b0;
        end
      end
      if (ifu_halt_req && ifu_req_valid) n_halt_req++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare delivered instructions with the reference stream

  always @(posedge clk) begin : compare_proc
    ifu_pkg::ir_out_t e;
    if (rst_n) begin
      // Delivery at this edge belongs to the stream before any flush in the cycle
      if (ifu_o_valid && ifu_o_ready) begin
        e = exp_q.pop_front();
        exp_q.push_back(expected_entry(next_pc_ref(e.pc)));
        check_value("pc", e.pc, ifu_o.pc);
        check_value("ir", e.ir, ifu_o.ir);
        check_value("buserr", {31'd0, e.buserr}, {31'd0, ifu_o.buserr});
        check_value("prdt_taken", {31'd0, e.prdt_taken}, {31'd0, ifu_o.prdt_taken});
        if (ifu_o.buserr) n_buserr++;
        n_deliv++;
      end
      if (pipe_flush_req) begin
        exp_q.delete();
        exp_q.push_back(expected_entry(pipe_flush_pc));
      end
    end
  end

  task automatic wait_deliveries(input int count);
    target = n_deliv + count;
    while (n_deliv < target) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic finish_test();
    $display("Test %s done with %0d errors", test_name, errors - base_err);
    base_err = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    rst_n = 1'b0;
    ifu_req_ready = 1'b0;
    ifu_rsp_valid = 1'b0;
    ifu_rsp = '0;
    ifu_o_ready = 1'b0;
    pipe_flush_req = 1'b0;
    pipe_flush_pc = '0;
    ifu_halt_req = 1'b0;
    seed = 32'h889e489e;
    {errors, n_checks, n_deliv, n_buserr, n_flush, n_flush_stall, n_halt_req} = '0;
    {cycle, base_err, n_redirect} = '0;
    {flush_en, halt_en, rsp_done, req_taken, mem_busy, flush_pend} = '0;
    flush_tgt = '0;
    first_req = 1'b1;
    exp_q.push_back(expected_entry(`IFU_RESET_PC));
    test_name = "reset_vector";
    wait_deliveries(N_RESET);
    finish_test();
    // Mixed lengths, jumps, both branch directions and the faulting fetch
    test_name = "stream";
    wait_deliveries(N_STREAM);
    check_value("faulting fetches seen", 32'd1, {31'd0, n_buserr > 0});
    finish_test();
    test_name = "flush";
    flush_en = 1'b1;
    wait_deliveries(N_FLUSH);
    flush_en = 1'b0;
    check_value("flush redirects seen", 32'd1, {31'd0, n_redirect > 0});
    $display("Flushes %0d, %0d with the request channel stalled", n_flush, n_flush_stall);
    finish_test();
    test_name = "halt";
    halt_en = 1'b1;
    while (!ifu_halt_ack) begin
      @(posedge clk);
      #1;
    end
    repeat (20) @(posedge clk);
    #1;
    check_value("requests while halted", 32'd0, n_halt_req);
    halt_en = 1'b0;
    wait_deliveries(N_RESUME);
    finish_test();
    $display("Summary: %0d checks, %0d errors", n_checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (LIMIT_CYCLES + 8) @(posedge clk);
    $display("Timeout in test %s after %0d cycles, the DUT stopped delivering",
             test_name, LIMIT_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire
